// File: flist.f
verilog/riscv_pkg.sv
verilog/btb_pred.sv
verilog/branch_resolve.sv
verilog/pred_perf_cnt.sv
verilog/bpu_top.sv
testbench/tb_bpu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the BPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bpu -f flist.f -o tb_bpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_bpu_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// File: testbench/tb_bpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bpu
    import riscv_pkg::*;
();

    logic             clk = 1'b0;
    logic             reset_n;
    logic             br_valid_i;
    br_info_t         br_info_i;
    logic             perf_clr_i;
    logic             res_valid_o;
    br_result_t       res_o;
    logic [CNT_W-1:0] cnt_branch_o;
    logic [CNT_W-1:0] cnt_mispred_o;

    // Model of the table, pointer and counters
    logic [XLEN-1:0]  m_pc    [PRED_SIZE];
    logic [XLEN-1:0]  m_tgt   [PRED_SIZE];
    pred_state_e      m_state [PRED_SIZE];
    logic             m_valid [PRED_SIZE];
    int               m_ptr;
    logic [CNT_W-1:0] m_cnt_br;
    logic [CNT_W-1:0] m_cnt_mp;

    br_result_t       exp_q [$];       // Results still owed by the DUT
    string            cur_test;
    int               test_errs;
    int               total_errs;
    int               checks;
    int               tests_run;
    int               tests_failed;
    logic             timeout_flag = 1'b0;
    int unsigned      seed_junk;

    bpu_top i_bpu_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .br_valid_i    (br_valid_i),
        .br_info_i     (br_info_i),
        .perf_clr_i    (perf_clr_i),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .cnt_branch_o  (cnt_branch_o),
        .cnt_mispred_o (cnt_mispred_o)
    );

    always #5 clk = ~clk;

    // ====================
    // Reference model
    // ====================
    function automatic int find_hit(logic [XLEN-1:0] pc);
        int h;
        h = -1;
        for (int i = 0; i < PRED_SIZE; i++) begin
            if (m_valid[i] && m_pc[i] == pc) h = i;
        end
        return h;
    endfunction

    function automatic br_result_t ref_result(br_info_t b);
        br_result_t r;
        int         h;
        h = find_hit(b.pc);
        r.pc          = b.pc;
        r.pred_hit    = (h >= 0);
        r.pred_target = '0;                // AND-OR mux gives zero on a miss
        r.pred_taken  = 1'b0;
        if (h >= 0) begin
            r.pred_target = m_tgt[h];
            r.pred_taken  = (m_state[h] >= PRED_WT);
        end
        r.mispredict = (r.pred_taken != b.taken) ||
                       (r.pred_taken && b.taken && r.pred_target != b.target);
        return r;
    endfunction

    function automatic pred_state_e next_state(pred_state_e s, logic taken);
        case (s)
            PRED_SNT: return taken ? PRED_WNT : PRED_SNT;
            PRED_WNT: return taken ? PRED_WT  : PRED_SNT;
            PRED_WT:  return taken ? PRED_ST  : PRED_WNT;
            default:  return taken ? PRED_ST  : PRED_WT;
        endcase
    endfunction

    task automatic train_model(br_info_t b, logic mispredict);
        int h;
        h = find_hit(b.pc);
        if (h >= 0) begin
            m_state[h] = next_state(m_state[h], b.taken);
        end else begin
            m_pc[m_ptr]    = b.pc;
            m_tgt[m_ptr]   = b.target;
            m_valid[m_ptr] = 1'b1;
            m_state[m_ptr] = PRED_WT;
            m_ptr          = (m_ptr + 1) % PRED_SIZE;
        end
        if (m_cnt_br != '1) m_cnt_br = m_cnt_br + 1'b1;
        if (mispredict && m_cnt_mp != '1) m_cnt_mp = m_cnt_mp + 1'b1;
    endtask

    // ====================
    // Compare tasks
    // ====================
    task automatic check_result(br_result_t exp, br_result_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s: result expected %h actual %h", cur_test, exp, act);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic check_count(string what, logic [CNT_W-1:0] exp, logic [CNT_W-1:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s: %s expected %0d actual %0d", cur_test, what, exp, act);
            test_errs++;
            total_errs++;
        end
    endtask

    initial begin : compare_results
        forever begin
            @(negedge clk);
            if (res_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("Test %s: res_valid_o went high with no branch pending",
                             cur_test);
                    test_errs++;
                    total_errs++;
                end else begin
                    check_result(exp_q.pop_front(), res_o);
                end
            end
        end
    end

    // ====================
    // Stimulus helpers
    // ====================
    task automatic send_branch(logic [XLEN-1:0] pc, logic [XLEN-1:0] tgt, logic taken);
        br_info_t   b;
        br_result_t e;
        b.pc     = pc;
        b.target = tgt;
        b.taken  = taken;
        e = ref_result(b);
        @(posedge clk);
        br_valid_i <= 1'b1;
        br_info_i  <= b;
        exp_q.push_back(e);
        train_model(b, e.mispredict);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            br_valid_i <= 1'b0;
        end
    endtask

    task automatic begin_test(string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        int t;
        t = 0;
        idle(1);
        while (exp_q.size() != 0 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("Test %s timed out waiting for %0d branch results", cur_test, exp_q.size());
            test_errs++;
            total_errs++;
            timeout_flag = 1'b1;
        end
        @(negedge clk);                    // Counts lag the result by a cycle
        check_count("branch count", m_cnt_br, cnt_branch_o);
        check_count("mispredict count", m_cnt_mp, cnt_mispred_o);
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("Test %s done with %0d errors", cur_test, test_errs);
    endtask

    // ====================
    // Watchdog
    // ====================
    initial begin : watchdog
        int cyc;
        cyc = 0;
        while (!timeout_flag && cyc < 20000) begin
            @(negedge clk);
            cyc++;
        end
        if (!timeout_flag) $display("Simulation did not finish within %0d cycles", cyc);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ====================
    // Test sequence
    // ====================
    initial begin : main_seq
        seed_junk  = $urandom(27439);
        reset_n    = 1'b0;
        br_valid_i = 1'b0;
        br_info_i  = '0;
        perf_clr_i = 1'b0;
        m_ptr      = 0;
        m_cnt_br   = '0;
        m_cnt_mp   = '0;
        for (int i = 0; i < PRED_SIZE; i++) begin
            m_valid[i] = 1'b0;
            m_state[i] = PRED_WT;
            m_pc[i]    = '0;
            m_tgt[i]   = '0;
        end
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        begin_test("reset_state");
        @(negedge clk);
        check_count("branch count", '0, cnt_branch_o);
        check_count("mispredict count", '0, cnt_mispred_o);
        idle(5);                           // Checker flags any stray result
        send_branch($urandom & 32'hffff_fffc, 32'h0000_0200, 1'b1);
        send_branch(32'h0000_0104, 32'h0000_0300, 1'b0);
        end_test();

        begin_test("counter_training");
        repeat (4) send_branch(32'h0000_1000, 32'h0000_1400, 1'b1);
        repeat (5) send_branch(32'h0000_1000, 32'h0000_1400, 1'b0);
        repeat (3) send_branch(32'h0000_1000, 32'h0000_1400, 1'b1);
        end_test();

        begin_test("replacement");
        for (int i = 0; i < PRED_SIZE + 2; i++) begin
            send_branch(32'h0000_2000 + 32'(4 * i), 32'h0000_3000 + 32'(16 * i), 1'b1);
        end
        send_branch(32'h0000_2000 + 32'(4 * (PRED_SIZE + 1)), 32'h0000_3000, 1'b1);
        send_branch(32'h0000_2000, 32'h0000_3000, 1'b1);  // Evicted early PC
        end_test();

        begin_test("target_mismatch");
        send_branch(32'h0000_4000, 32'h0000_4100, 1'b1);
        send_branch(32'h0000_4000, 32'h0000_4800, 1'b1);
        send_branch(32'h0000_4000, 32'h0000_4100, 1'b1);  // Stored target kept
        end_test();

        begin_test("random_run");
        for (int n = 0; n < 400; n++) begin
            send_branch(32'h0000_5000 + 4 * ($urandom % 8),
                        32'h0000_6000 + 16 * ($urandom % 3),
                        ($urandom % 2) == 1);
            idle($urandom % 3);
        end
        end_test();

        begin_test("counter_clear");
        @(posedge clk);
        perf_clr_i <= 1'b1;
        @(posedge clk);
        perf_clr_i <= 1'b0;
        m_cnt_br = '0;
        m_cnt_mp = '0;
        @(negedge clk);
        check_count("branch count", '0, cnt_branch_o);
        check_count("mispredict count", '0, cnt_mispred_o);
        send_branch(32'h0000_7000, 32'h0000_7100, 1'b1);
        send_branch(32'h0000_7000, 32'h0000_7100, 1'b1);
        send_branch(32'h0000_7004, 32'h0000_7200, 1'b0);
        end_test();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errs);
        if (total_errs == 0 && !timeout_flag) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_top
    import riscv_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_n,

    input  wire logic        br_valid_i,
    input  wire br_info_t    br_info_i,
    input  wire logic        perf_clr_i,

    output logic             res_valid_o,
    output br_result_t       res_o,
    output logic [CNT_W-1:0] cnt_branch_o,
    output logic [CNT_W-1:0] cnt_mispred_o
);

    // ====================
    // Resolve to predictor
    // ====================
    logic            pred_en;
    logic [XLEN-1:0] bu_pc_branch;
    logic [XLEN-1:0] bu_pc_target;
    logic            bu_pred_success;
    logic            bu_pred_failed;
    logic [XLEN-1:0] pred_pc;
    logic            pred_taken;
    logic            pred_v;

    branch_resolve i_branch_resolve (
        .clk               (clk),
        .reset_n           (reset_n),
        .br_valid_i        (br_valid_i),
        .br_info_i         (br_info_i),
        .pred_pc_i         (pred_pc),
        .pred_taken_i      (pred_taken),
        .pred_v_i          (pred_v),
        .pred_en_o         (pred_en),
        .bu_pc_branch_o    (bu_pc_branch),
        .bu_pc_target_o    (bu_pc_target),
        .bu_pred_success_o (bu_pred_success),
        .bu_pred_failed_o  (bu_pred_failed),
        .res_valid_o       (res_valid_o),
        .res_o             (res_o)
    );

    btb_pred i_btb_pred (
        .clk               (clk),
        .reset_n           (reset_n),
        .pred_en_i         (pred_en),
        .bu_pc_branch_i    (bu_pc_branch),
        .bu_pc_target_i    (bu_pc_target),
        .bu_pred_success_i (bu_pred_success),
        .bu_pred_failed_i  (bu_pred_failed),
        .pred_pc_o         (pred_pc),
        .pred_taken_o      (pred_taken),
        .pred_v_o          (pred_v)
    );

    pred_perf_cnt i_pred_perf_cnt (
        .clk           (clk),
        .reset_n       (reset_n),
        .perf_clr_i    (perf_clr_i),
        .res_valid_i   (res_valid_o),     // Counts lag the result by a cycle
        .res_i         (res_o),
        .cnt_branch_o  (cnt_branch_o),
        .cnt_mispred_o (cnt_mispred_o)
    );

endmodule

`default_nettype wire

// File: verilog/pred_perf_cnt.sv
`timescale 1ns/1ns
`default_nettype none

module pred_perf_cnt
    import riscv_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_n,

    input  wire logic       perf_clr_i,
    input  wire logic       res_valid_i,
    input  wire br_result_t res_i,

    output logic [CNT_W-1:0] cnt_branch_o,
    output logic [CNT_W-1:0] cnt_mispred_o
);

    logic [CNT_W-1:0] branch_q;
    logic [CNT_W-1:0] mispred_q;

    // Both counts stick at all-ones
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            branch_q  <= '0;
            mispred_q <= '0;
        end else if (perf_clr_i) begin
            branch_q  <= '0;             // Clear wins over counting
            mispred_q <= '0;
        end else if (res_valid_i) begin
            if (branch_q != '1) begin
                branch_q <= branch_q + 1'b1;
            end
            if (res_i.mispredict && (mispred_q != '1)) begin
                mispred_q <= mispred_q + 1'b1;
            end
        end
    end

    assign cnt_branch_o  = branch_q;
    assign cnt_mispred_o = mispred_q;

endmodule

`default_nettype wire

// File: verilog/branch_resolve.sv
`timescale 1ns/1ns
`default_nettype none

module branch_resolve
    import riscv_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset_n,

    // Execute stage
    input  wire logic            br_valid_i,
    input  wire br_info_t        br_info_i,

    // Predictor answer
    input  wire logic [XLEN-1:0] pred_pc_i,
    input  wire logic            pred_taken_i,
    input  wire logic            pred_v_i,

    // Predictor lookup and training
    output logic                 pred_en_o,
    output logic [XLEN-1:0]      bu_pc_branch_o,
    output logic [XLEN-1:0]      bu_pc_target_o,
    output logic                 bu_pred_success_o,
    output logic                 bu_pred_failed_o,

    // Outcome
    output logic                 res_valid_o,
    output br_result_t           res_o
);

    logic     valid_q;
    br_info_t info_q;
    logic     taken_pred;
    logic     target_wrong;

    // ====================
    // Stage register
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= br_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (br_valid_i) begin
            info_q <= br_info_i;
        end
    end

    assign pred_en_o         = valid_q;
    assign bu_pc_branch_o    = info_q.pc;
    assign bu_pc_target_o    = info_q.target;
    assign bu_pred_success_o = valid_q & info_q.taken;
    assign bu_pred_failed_o  = valid_q & ~info_q.taken;

    // ====================
    // Misprediction check
    // ====================
    assign taken_pred   = pred_v_i & pred_taken_i;     // A miss predicts not taken
    assign target_wrong = taken_pred & info_q.taken & (pred_pc_i != info_q.target);

    assign res_valid_o       = valid_q;
    assign res_o.pc          = info_q.pc;
    assign res_o.pred_target = pred_pc_i;
    assign res_o.pred_hit    = pred_v_i;
    assign res_o.pred_taken  = taken_pred;
    assign res_o.mispredict  = (taken_pred != info_q.taken) | target_wrong;

    a_train_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(bu_pred_success_o && bu_pred_failed_o));

endmodule

`default_nettype wire

// File: verilog/btb_pred.sv
`timescale 1ns/1ns
`default_nettype none

module btb_pred
    import riscv_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset_n,

    input  wire logic            pred_en_i,
    input  wire logic [XLEN-1:0] bu_pc_branch_i,
    input  wire logic [XLEN-1:0] bu_pc_target_i,
    input  wire logic            bu_pred_success_i,
    input  wire logic            bu_pred_failed_i,

    output logic [XLEN-1:0]      pred_pc_o,
    output logic                 pred_taken_o,
    output logic                 pred_v_o
);

    // ====================
    // Table storage
    // ====================
    logic [XLEN-1:0]      branch_q [PRED_SIZE];    // PC tags
    logic [XLEN-1:0]      target_q [PRED_SIZE];
    pred_state_e          state_q  [PRED_SIZE];
    pred_state_e          state_d  [PRED_SIZE];
    logic [PRED_SIZE-1:0] valid_q;

    logic [PRED_SIZE-1:0] wptr_q;                  // One-hot round-robin pointer
    logic [PRED_SIZE-1:0] wptr_d;

    logic [PRED_SIZE-1:0] hits;                    // One-hot or zero
    logic                 miss;
    logic [PRED_SIZE-1:0] alloc_we;
    logic [PRED_SIZE-1:0] train_we;

    logic [XLEN-1:0]      target_mux;
    logic [1:0]           state_mux;

    // ====================
    // Lookup
    // ====================
    always_comb begin
        for (int i = 0; i < PRED_SIZE; i++) begin
            hits[i] = valid_q[i] && (branch_q[i] == bu_pc_branch_i);
        end
    end

    assign miss     = ~|hits;
    assign alloc_we = wptr_q & {PRED_SIZE{pred_en_i & miss}};
    assign train_we = hits & {PRED_SIZE{pred_en_i}};

    assign wptr_d   = {wptr_q[PRED_SIZE-2:0], wptr_q[PRED_SIZE-1]};  // Wraps to entry 0

    // Saturating counter update and allocation at weakly taken
    always_comb begin
        for (int i = 0; i < PRED_SIZE; i++) begin
            state_d[i] = state_q[i];
            if (alloc_we[i]) begin
                state_d[i] = PRED_WT;
            end else if (train_we[i]) begin
                if (bu_pred_success_i && (state_q[i] != PRED_ST)) begin
                    state_d[i] = pred_state_e'(state_q[i] + 2'd1);
                end else if (bu_pred_failed_i && (state_q[i] != PRED_SNT)) begin
                    state_d[i] = pred_state_e'(state_q[i] - 2'd1);
                end
            end
        end
    end

    // ====================
    // Registers
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= '0;
            wptr_q  <= PRED_SIZE'(1);                // Entry 0
            for (int i = 0; i < PRED_SIZE; i++) begin
                state_q[i] <= PRED_WT;
            end
        end else begin
            valid_q <= valid_q | alloc_we;
            if (pred_en_i && miss) begin
                wptr_q <= wptr_d;
            end
            for (int i = 0; i < PRED_SIZE; i++) begin
                state_q[i] <= state_d[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < PRED_SIZE; i++) begin
            if (alloc_we[i]) begin
                branch_q[i] <= bu_pc_branch_i;
                target_q[i] <= bu_pc_target_i;   // Not rewritten on a hit
            end
        end
    end

    // ====================
    // Output mux
    // ====================
    always_comb begin
        target_mux = '0;
        state_mux  = '0;
        for (int j = 0; j < PRED_SIZE; j++) begin
            target_mux = target_mux | (target_q[j] & {XLEN{hits[j]}});
            state_mux  = state_mux  | (state_q[j]  & {2{hits[j]}});
        end
    end

    assign pred_pc_o    = target_mux;
    assign pred_taken_o = state_mux[1];
    assign pred_v_o     = ~miss;

    // Allocation only on a miss keeps tags unique
    a_hits_onehot0: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(hits));

    a_wptr_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot(wptr_q));

endmodule

`default_nettype wire

// File: verilog/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int XLEN      = 32;  // Address width
    localparam int PRED_SIZE = 4;   // BTB entries (2 or more)
    localparam int CNT_W     = 16;  // Performance counter width

    // ====================
    // Direction counter
    // ====================
    // Upper bit gives the taken prediction
    typedef enum logic [1:0] {
        PRED_SNT = 2'd0,            // Strongly not taken
        PRED_WNT = 2'd1,            // Weakly not taken
        PRED_WT  = 2'd2,            // Weakly taken
        PRED_ST  = 2'd3             // Strongly taken
    } pred_state_e;

    // ====================
    // Branch records
    // ====================
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        logic            taken;
    } br_info_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pred_target;
        logic            pred_hit;
        logic            pred_taken;
        logic            mispredict;
    } br_result_t;

endpackage

`default_nettype wire
